/* all.f */
verilog/cm3BusPkg.sv
verilog/codeMux.sv
verilog/sysBusBridge.sv
verilog/cm3BusFabric.sv
dv/cm3BusFabric_assertions.sv
dv/cm3BusFabricTb.sv

/* run.sh */
#!/bin/bash
# Build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module cm3BusFabricTb -Mdir build
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./build/Vcm3BusFabricTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "^test passed$" sim.log; then
   exit 0
else
   echo "Pass message not found in sim.log"
   exit 1
fi

/* dv/cm3BusFabricTb.sv */
// Cortex-M3 bus fabric testbench
`timescale 1ns/1ns
`default_nettype none

module cm3BusFabricTb
   import cm3BusPkg::*;
();

   typedef enum {srcIcode, srcDcode, srcSys} master_t;

   logic     HCLK;
   logic     reset;
   logic     halted;
   ahbReq_t  icodeReq;
   ahbReq_t  dcodeReq;
   ahbReq_t  sysReqIn;
   logic     dcodeExreq;
   logic     sysExreq;
   ahbResp_t icodeResp;
   ahbResp_t dcodeResp;
   ahbResp_t sysRespOut;
   logic     dcodeExresp;
   logic     sysExresp;
   ahbReq_t  codeReq;
   ahbReq_t  sysReq;
   ahbResp_t codeResp = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
   ahbResp_t sysResp  = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};

   logic [31:0] codeMem [256];     // Code slave storage
   logic [31:0] codeModel [256];   // Expected code contents
   ahbReq_t     codeLog[$];        // Address phases seen by the code slave
   ahbReq_t     sysLog[$];
   logic        cdWrite;
   logic        cdValid;
   logic [7:0]  cdIdx;
   int          cdWait;
   int          sdWait;
   int          codeWaitPick;
   int          sysWaitPick;
   logic        modelMonValid;     // Expected exclusive monitor
   logic [29:0] modelMonAddr;
   int          checks;
   int          errors;
   int          cycles;

   cm3BusFabric uut (.*);

   always #50 HCLK = ~HCLK;

   // Run limit covers every test with a wide margin
   always @(posedge HCLK) begin
      cycles++;
      if (cycles >= 4000) begin
         $display("Timeout after %0d cycles, a transfer never completed", cycles);
         $display("test failed");
         $finish;
      end
   end

   function automatic logic [31:0] fillWord(input logic [31:0] a);
      return {a[15:0] ^ 16'ha5c3, a[31:16]} ^ (a * 32'h9e37_79b9);
   endfunction

   function automatic ahbReq_t stripData(input ahbReq_t r);
      ahbReq_t s;
      s = r;
      s.hwdata = '0;   // Write data is not part of the address phase
      return s;
   endfunction

   function automatic logic [31:0] remap(input logic [31:0] a);
      if (a >= sramBase && a < sramBase + ramSize) begin
         return a - sramBase + romSize;
      end
      return a;
   endfunction

   // Code slave with random wait states
   always @(posedge HCLK) begin
      if (reset) begin
         codeResp <= '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
         cdValid  <= 1'b0;
      end else if (codeResp.hready) begin
         if (cdValid && cdWrite) begin
            codeMem[cdIdx] = codeReq.hwdata;
         end
         cdValid <= codeReq.htrans inside {transNonseq, transSeq};
         if (codeReq.htrans inside {transNonseq, transSeq}) begin
            codeLog.push_back(stripData(codeReq));
            cdIdx   <= codeReq.haddr[9:2];
            cdWrite <= codeReq.hwrite;
            codeResp.hrdata <= codeMem[codeReq.haddr[9:2]];
            codeWaitPick = $urandom % 3;
            cdWait <= codeWaitPick;
            codeResp.hready <= (codeWaitPick == 0);
         end
      end else begin
         cdWait <= cdWait - 1;
         if (cdWait == 1) codeResp.hready <= 1'b1;
      end
   end

   // Sys slave returns a fixed pattern per address
   always @(posedge HCLK) begin
      if (reset) begin
         sysResp <= '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
      end else if (sysResp.hready) begin
         if (sysReq.htrans inside {transNonseq, transSeq}) begin
            sysLog.push_back(stripData(sysReq));
            sysResp.hrdata <= fillWord(sysReq.haddr);
            sysWaitPick = $urandom % 3;
            sdWait <= sysWaitPick;
            sysResp.hready <= (sysWaitPick == 0);
         end
      end else begin
         sdWait <= sdWait - 1;
         if (sdWait == 1) sysResp.hready <= 1'b1;
      end
   end

   task automatic checkResp(input string name, input ahbResp_t exp, input ahbResp_t act);
      checks++;
      if (exp.hrdata !== act.hrdata || exp.hresp !== act.hresp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %h/%b, got %h/%b", $time, name,
                  exp.hrdata, exp.hresp, act.hrdata, act.hresp);
      end
   endtask

   task automatic checkReq(input string name, input ahbReq_t exp, input ahbReq_t act);
      checks++;
      if (stripData(exp) !== stripData(act)) begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name,
                  stripData(exp), stripData(act));
      end
   endtask

   task automatic checkExresp(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   function automatic ahbResp_t respOf(input master_t src);
      case (src)
         srcIcode: return icodeResp;
         srcDcode: return dcodeResp;
         default:  return sysRespOut;
      endcase
   endfunction

   task automatic drive(input master_t src, input ahbReq_t req, input logic ex);
      case (src)
         srcIcode: icodeReq <= req;
         srcDcode: begin
            dcodeReq   <= req;
            dcodeExreq <= ex;
         end
         default: begin
            sysReqIn <= req;
            sysExreq <= ex;
         end
      endcase
   endtask

   // One transfer, called and returning just after a rising edge
   task automatic access(input master_t src, input logic [31:0] addr, input logic wr,
                         input logic [31:0] wdata, input logic ex,
                         output ahbResp_t resp, output logic exr);
      ahbReq_t req;
      req = '{haddr: addr, htrans: transNonseq, hwrite: wr, hsize: 3'd2, hwdata: '0};
      drive(src, req, ex);
      @(posedge HCLK);
      while (!respOf(src).hready) @(posedge HCLK);
      req.htrans = transIdle;
      req.hwdata = wdata;
      drive(src, req, 1'b0);
      @(posedge HCLK);
      while (!respOf(src).hready) @(posedge HCLK);
      resp = respOf(src);
      exr  = (src == srcSys) ? sysExresp : dcodeExresp;
   endtask

   task automatic codeStep(input master_t src, input logic [31:0] addr, input logic wr,
                           input logic ex);
      ahbResp_t    resp;
      logic        exr;
      logic [31:0] wdata;
      wdata = $urandom;
      access(src, addr, wr, wdata, ex, resp, exr);
      if (wr) begin
         codeModel[addr[9:2]] = wdata;
      end else begin
         checkResp(src == srcIcode ? "icodeResp" : "dcodeResp",
                   '{hrdata: codeModel[addr[9:2]], hready: 1'b1, hresp: 1'b0}, resp);
      end
      if (src == srcDcode) checkExresp("dcodeExresp", ex, exr);   // Code bus never grants
   endtask

   task automatic sysStep(input logic [31:0] addr, input logic wr, input logic ex);
      ahbResp_t    resp;
      ahbReq_t     expReq;
      logic        exr;
      logic        fail;
      logic [31:0] mapped;
      fail   = ex && wr && !(modelMonValid && modelMonAddr == addr[31:2]);
      mapped = remap(addr);
      expReq = '{haddr: mapped, htrans: transNonseq, hwrite: wr && !fail, hsize: 3'd2,
                 hwdata: '0};
      sysLog.delete();
      access(srcSys, addr, wr, $urandom, ex, resp, exr);
      checkReq("sysReq", expReq, sysLog[0]);
      if (!expReq.hwrite) begin
         checkResp("sysRespOut", '{hrdata: fillWord(mapped), hready: 1'b1, hresp: 1'b0}, resp);
      end
      if (ex && wr) checkExresp("sysExresp", fail, exr);
      if (ex && !wr) begin
         modelMonValid = 1'b1;
         modelMonAddr  = addr[31:2];
      end else if (ex) begin
         modelMonValid = 1'b0;
      end else if (wr && modelMonValid && modelMonAddr == addr[31:2]) begin
         modelMonValid = 1'b0;
      end
   endtask

   task automatic reportTest(input string name, input int errStart);
      $display("%s: %0d errors", name, errors - errStart);
   endtask

   initial begin
      int          errStart;
      int          iDone;
      int          dDone;
      int          iSeen;
      int          dSeen;
      int          pick;
      logic [31:0] ia;
      logic [31:0] da;
      logic        dw;
      void'($urandom(32'h638c_4600));
      HCLK       = 1'b0;
      reset      = 1'b1;
      halted     = 1'b0;
      icodeReq   = '0;
      dcodeReq   = '0;
      sysReqIn   = '0;
      dcodeExreq = 1'b0;
      sysExreq   = 1'b0;
      modelMonValid = 1'b0;
      modelMonAddr  = '0;
      for (int i = 0; i < 256; i++) begin
         codeMem[i]   = fillWord(i * 4);
         codeModel[i] = fillWord(i * 4);
      end
      repeat (5) @(posedge HCLK);
      reset <= 1'b0;
      @(posedge HCLK);

      // Icode reads the lower half, dcode owns the upper half
      errStart = errors;
      repeat (100) codeStep(srcDcode, 32'h200 | ($urandom & 32'h1fc), 1'($urandom), 1'b0);
      repeat (50) codeStep(srcIcode, $urandom & 32'h1fc, 1'b0, 1'b0);
      reportTest("test 1 single master code access", errStart);

      errStart = errors;
      repeat (60) begin
         ia = $urandom & 32'h1fc;
         da = 32'h200 | ($urandom & 32'h1fc);
         dw = 1'($urandom);
         codeLog.delete();
         fork
            codeStep(srcIcode, ia, 1'b0, 1'b0);
            codeStep(srcDcode, da, dw, 1'b0);
         join
         checkReq("codeReq", '{haddr: da, htrans: transNonseq, hwrite: dw, hsize: 3'd2,
                  hwdata: '0}, codeLog[0]);
      end
      reportTest("test 2 simultaneous icode and dcode", errStart);

      errStart = errors;
      iDone = 0;
      dDone = 0;
      codeLog.delete();
      fork
         repeat (60) begin
            repeat ($urandom % 2) @(posedge HCLK);
            codeStep(srcIcode, $urandom & 32'h1fc, 1'b0, 1'b0);
            iDone++;
         end
         repeat (60) begin
            repeat ($urandom % 2) @(posedge HCLK);
            codeStep(srcDcode, 32'h200 | ($urandom & 32'h1fc), 1'($urandom), 1'b0);
            dDone++;
         end
      join
      iSeen = 0;
      dSeen = 0;
      foreach (codeLog[k]) begin
         if (codeLog[k].haddr[9]) begin
            dSeen++;   // Upper half belongs to dcode
         end else begin
            iSeen++;
         end
      end
      checks++;
      if (iSeen != iDone || dSeen != dDone) begin
         errors++;
         $display("Transfer count wrong: icode %0d done %0d seen, dcode %0d done %0d seen",
                  iDone, iSeen, dDone, dSeen);
      end
      reportTest("test 3 concurrent traffic with wait states", errStart);

      errStart = errors;
      repeat (80) begin
         pick = $urandom % 4;
         case (pick)
            0: ia = sramBase + (($urandom % ramSize) & 32'hffff_fffc);
            1: ia = $urandom & 32'h0000_fffc;
            2: ia = 32'h4000_0000 | ($urandom & 32'h0000_fffc);
            default: ia = sramBase + ramSize + ($urandom & 32'h0000_00fc);   // Just past the window
         endcase
         sysStep(ia, 1'($urandom), 1'b0);
      end
      reportTest("test 4 sys address remap", errStart);

      errStart = errors;
      repeat (30) begin
         ia   = sramBase + (($urandom % ramSize) & 32'hffff_fffc);
         pick = $urandom % 3;
         sysStep(ia, 1'b0, 1'b1);
         if (pick == 1) sysStep(ia, 1'b1, 1'b0);
         if (pick == 2) begin
            halted <= 1'b1;
            @(posedge HCLK);
            halted <= 1'b0;
            modelMonValid = 1'b0;
         end
         sysStep(ia, 1'b1, 1'b1);
      end
      repeat (10) codeStep(srcDcode, 32'h200 | ($urandom & 32'h1fc), 1'($urandom), 1'b1);
      reportTest("test 5 exclusive access", errStart);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dv/cm3BusFabric_assertions.sv */
// Code mux protocol assertions
`timescale 1ns/1ns
`default_nettype none

module cm3BusFabric_assertions
   import cm3BusPkg::*;
(
   input logic     HCLK,
   input logic     reset,
   input ahbReq_t  icodeReq,
   input ahbResp_t icodeResp,
   input ahbReq_t  dcodeReq,
   input ahbResp_t dcodeResp,
   input ahbReq_t  codeReq
);

   logic [37:0] iPhase;   // Address phase fields without write data
   logic [37:0] dPhase;
   logic        iActive;
   logic        dActive;

   assign iPhase  = {icodeReq.haddr, icodeReq.htrans, icodeReq.hwrite, icodeReq.hsize};
   assign dPhase  = {dcodeReq.haddr, dcodeReq.htrans, dcodeReq.hwrite, dcodeReq.hsize};
   assign iActive = icodeReq.htrans inside {transNonseq, transSeq};
   assign dActive = dcodeReq.htrans inside {transNonseq, transSeq};

   icodeHeld: assert property (@(posedge HCLK) disable iff (reset)
      (iActive && !icodeResp.hready) |=> $stable(iPhase))
      else $error("icode address phase changed while stalled");

   dcodeHeld: assert property (@(posedge HCLK) disable iff (reset)
      (dActive && !dcodeResp.hready) |=> $stable(dPhase))
      else $error("dcode address phase changed while stalled");

   // First cycle out of reset
   idleAfterReset: assert property (@(posedge HCLK)
      $fell(reset) |-> codeReq.htrans == transIdle)
      else $error("code bus not idle after reset");

endmodule

bind codeMux cm3BusFabric_assertions codeMuxChecks (.*);

`default_nettype wire

/* verilog/cm3BusFabric.sv */
// Cortex-M3 bus fabric top
`timescale 1ns/1ns
`default_nettype none

module cm3BusFabric
   import cm3BusPkg::*;
(
   input  logic     HCLK,
   input  logic     reset,
   input  logic     halted,
   // Instruction code master
   input  ahbReq_t  icodeReq,
   output ahbResp_t icodeResp,
   // Data code master
   input  ahbReq_t  dcodeReq,
   input  logic     dcodeExreq,
   output ahbResp_t dcodeResp,
   output logic     dcodeExresp,
   // System master
   input  ahbReq_t  sysReqIn,
   input  logic     sysExreq,
   output ahbResp_t sysRespOut,
   output logic     sysExresp,
   // Slave side buses
   output ahbReq_t  codeReq,
   input  ahbResp_t codeResp,
   output ahbReq_t  sysReq,
   input  ahbResp_t sysResp
);

   assign sysRespOut = sysResp;   // System replies need no change

   codeMux uCodeMux (
      .HCLK        (HCLK),
      .reset       (reset),
      .icodeReq    (icodeReq),
      .icodeResp   (icodeResp),
      .dcodeReq    (dcodeReq),
      .dcodeExreq  (dcodeExreq),
      .dcodeResp   (dcodeResp),
      .dcodeExresp (dcodeExresp),
      .codeReq     (codeReq),
      .codeResp    (codeResp)
   );

   // Remap and exclusive monitor on the system path
   sysBusBridge uSysBridge (
      .HCLK      (HCLK),
      .reset     (reset),
      .halted    (halted),
      .sysReqIn  (sysReqIn),
      .sysExreq  (sysExreq),
      .sysHready (sysResp.hready),
      .sysExresp (sysExresp),
      .sysReq    (sysReq)
   );

endmodule

`default_nettype wire

/* verilog/sysBusBridge.sv */
// System bus remap and exclusive monitor
`timescale 1ns/1ns
`default_nettype none

module sysBusBridge
   import cm3BusPkg::*;
(
   input  logic    HCLK,
   input  logic    reset,
   input  logic    halted,      // Debug halt clears the monitor
   input  ahbReq_t sysReqIn,
   input  logic    sysExreq,
   input  logic    sysHready,
   output logic    sysExresp,
   output ahbReq_t sysReq
);

   logic        sysActive;
   logic        accept;
   logic        inWindow;
   logic        addrMatch;
   logic        exStoreFail;
   logic        monValid;
   logic [29:0] monAddr;     // Word address of the last exclusive read

   assign sysActive = (sysReqIn.htrans == transNonseq) || (sysReqIn.htrans == transSeq);
   assign accept    = sysActive && sysHready;

   // Data placed directly after ROM in one memory
   assign inWindow = (sysReqIn.haddr >= sramBase) && (sysReqIn.haddr < (sramBase + ramSize));

   assign addrMatch   = monValid && (monAddr == sysReqIn.haddr[31:2]);
   assign exStoreFail = sysExreq && sysReqIn.hwrite && !addrMatch;

   always_comb begin
      sysReq = sysReqIn;
      if (inWindow) begin
         sysReq.haddr = sysReqIn.haddr - sramBase + romSize;
      end
      // A failed store exclusive goes out as a harmless read
      if (exStoreFail) begin
         sysReq.hwrite = 1'b0;
      end
   end

   // Monitor state
   always_ff @(posedge HCLK) begin
      if (reset) begin
         monValid <= 1'b0;
      end else if (halted) begin
         monValid <= 1'b0;
      end else if (accept) begin
         if (sysExreq && !sysReqIn.hwrite) begin
            monValid <= 1'b1;
         end else if (sysExreq) begin
            monValid <= 1'b0;                // Any store exclusive ends the sequence
         end else if (sysReqIn.hwrite && addrMatch) begin
            monValid <= 1'b0;                // Plain write to the watched word
         end
      end
   end

   always_ff @(posedge HCLK) begin
      if (accept && sysExreq && !sysReqIn.hwrite) begin
         monAddr <= sysReqIn.haddr[31:2];
      end
   end

   // Exclusive result for the data phase
   always_ff @(posedge HCLK) begin
      if (reset) begin
         sysExresp <= 1'b0;
      end else if (sysHready) begin
         sysExresp <= sysActive && exStoreFail;
      end
   end

endmodule

`default_nettype wire

/* verilog/codeMux.sv */
// Icode and dcode arbiter
`timescale 1ns/1ns
`default_nettype none

module codeMux
   import cm3BusPkg::*;
(
   input  logic     HCLK,
   input  logic     reset,
   // Instruction fetch master
   input  ahbReq_t  icodeReq,
   output ahbResp_t icodeResp,
   // Data master, wins every tie
   input  ahbReq_t  dcodeReq,
   input  logic     dcodeExreq,
   output ahbResp_t dcodeResp,
   output logic     dcodeExresp,
   // Shared code bus
   output ahbReq_t  codeReq,
   input  ahbResp_t codeResp
);

   logic       iActive;
   logic       dActive;
   logic       busReady;
   logic       iLoses;      // Icode address accepted but bus taken by dcode
   logic       pendValid;
   ahbReq_t    pendReq;     // Held icode address phase
   codeOwner_t owner;       // Whose data phase is on the bus
   logic       dExPhase;

   assign iActive  = (icodeReq.htrans == transNonseq) || (icodeReq.htrans == transSeq);
   assign dActive  = (dcodeReq.htrans == transNonseq) || (dcodeReq.htrans == transSeq);
   assign busReady = codeResp.hready;

   // Icode only gets accepted while nothing is pending
   assign iLoses = busReady && dActive && iActive && !pendValid;

   // Address phase select
   always_comb begin
      codeReq        = icodeReq;
      codeReq.hwrite = 1'b0;             // Instruction side is read only
      if (dActive) begin
         codeReq = dcodeReq;
      end else if (pendValid) begin
         codeReq        = pendReq;
         codeReq.hwrite = 1'b0;
         codeReq.htrans = transNonseq;   // Dcode broke any icode burst
      end else if (iActive && (owner != ownIcode)) begin
         codeReq.htrans = transNonseq;
      end
      codeReq.hwdata = dcodeReq.hwdata;  // Only dcode ever has write data
   end

   // Data phase tracking
   always_ff @(posedge HCLK) begin
      if (reset) begin
         owner     <= ownNone;
         pendValid <= 1'b0;
         dExPhase  <= 1'b0;
      end else if (busReady) begin
         dExPhase <= dActive && dcodeExreq;
         if (dActive) begin
            owner <= ownDcode;
            if (iLoses) begin
               pendValid <= 1'b1;
            end
         end else if (pendValid) begin
            owner     <= ownIcode;       // Held request goes out now
            pendValid <= 1'b0;
         end else if (iActive) begin
            owner <= ownIcode;
         end else begin
            owner <= ownNone;
         end
      end
   end

   // Capture of the losing icode request
   always_ff @(posedge HCLK) begin
      if (iLoses) begin
         pendReq <= icodeReq;
      end
   end

   // Responses back to the masters
   always_comb begin
      icodeResp.hrdata = (owner == ownIcode) ? codeResp.hrdata : '0;
      icodeResp.hresp  = (owner == ownIcode) && codeResp.hresp;
      icodeResp.hready = busReady && !pendValid;   // Low until held fetch completes

      dcodeResp.hrdata = (owner == ownDcode) ? codeResp.hrdata : '0;
      dcodeResp.hresp  = (owner == ownDcode) && codeResp.hresp;
      dcodeResp.hready = busReady;
   end

   // No exclusive monitor on the code bus so every exclusive fails
   assign dcodeExresp = dExPhase;

endmodule

`default_nettype wire

/* verilog/cm3BusPkg.sv */
// Cortex-M3 bus fabric types
`default_nettype none

package cm3BusPkg;

   // Address map
   localparam logic [31:0] sramBase = 32'h2000_0000;
   localparam logic [31:0] romSize  = 32'h0001_0000;  // 64 KB of ROM ahead of data
   localparam logic [31:0] ramSize  = 32'h0000_8000;  // 32 KB SRAM window

   // AHB transfer type
   typedef enum logic [1:0] {
      transIdle   = 2'b00,
      transBusy   = 2'b01,
      transNonseq = 2'b10,
      transSeq    = 2'b11
   } htrans_t;

   // Address phase plus write data of one master
   typedef struct packed {
      logic [31:0] haddr;
      htrans_t     htrans;
      logic        hwrite;
      logic [2:0]  hsize;   // Byte, halfword or word
      logic [31:0] hwdata;  // Valid in the data phase
   } ahbReq_t;

   // Slave reply
   typedef struct packed {
      logic [31:0] hrdata;
      logic        hready;
      logic        hresp;   // High on error
   } ahbResp_t;

   // Owner of the code bus data phase
   typedef enum logic [1:0] {
      ownNone  = 2'b00,
      ownIcode = 2'b01,
      ownDcode = 2'b10
   } codeOwner_t;

endpackage

`default_nettype wire
